/* Bender.yml */
package:
  name: rv_core

sources:
  - design/rv_pkg.sv
  - design/rv_regfile.sv
  - design/rv_fetch.sv
  - design/rv_decode.sv
  - design/rv_execute.sv
  - design/rv_memory.sv
  - design/rv_hazard.sv
  - design/rv_core.sv
  - target: simulation
    files:
      - sim/rv_mem_model.sv
      - sim/rv_core_tb.sv

/* design/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
  parameter rv_pkg::xlen_t RESET_PC = 32'h0000_0000
) (
  input  wire                clk,
  input  wire                rst_n,
  output logic               imem_ren,
  output rv_pkg::xlen_t      imem_raddr,
  input  wire rv_pkg::xlen_t imem_rdata,
  output logic               dmem_ren,
  output rv_pkg::xlen_t      dmem_raddr,
  input  wire rv_pkg::xlen_t dmem_rdata,
  output logic               dmem_we,
  output rv_pkg::xlen_t      dmem_waddr,
  output rv_pkg::xlen_t      dmem_wdata,
  output logic [3:0]         dmem_wstrb,
  output logic               ebreak
);
  import rv_pkg::*;

  // ------------------------------------------------------------------------
  // Stage registers and side channels
  // ------------------------------------------------------------------------
  if_id_t      if_id;
  id_ex_t      id_ex;
  ex_mem_t     ex_mem;
  mem_wb_t     wb;
  redirect_t   redirect;
  hazard_ctl_t hazard;

  // Decode to hazard
  reg_idx_t rs1;
  reg_idx_t rs2;
  logic     rs1_used;
  logic     rs2_used;

  rv_fetch #(
    .RESET_PC (RESET_PC)
  ) u_fetch (
    .clk        (clk),
    .rst_n      (rst_n),
    .redirect   (redirect),
    .hazard     (hazard),
    .imem_ren   (imem_ren),
    .imem_raddr (imem_raddr),
    .imem_rdata (imem_rdata),
    .if_id      (if_id)
  );

  rv_decode u_decode (
    .clk      (clk),
    .rst_n    (rst_n),
    .if_id    (if_id),
    .wb       (wb),
    .hazard   (hazard),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_used (rs1_used),
    .rs2_used (rs2_used),
    .id_ex    (id_ex)
  );

  // Memory stage forwards through its own input register
  rv_execute u_execute (
    .clk      (clk),
    .rst_n    (rst_n),
    .id_ex    (id_ex),
    .mem_fwd  (ex_mem),
    .wb       (wb),
    .redirect (redirect),
    .ex_mem   (ex_mem)
  );

  rv_memory u_memory (
    .clk        (clk),
    .rst_n      (rst_n),
    .ex_mem     (ex_mem),
    .dmem_ren   (dmem_ren),
    .dmem_raddr (dmem_raddr),
    .dmem_rdata (dmem_rdata),
    .dmem_we    (dmem_we),
    .dmem_waddr (dmem_waddr),
    .dmem_wdata (dmem_wdata),
    .dmem_wstrb (dmem_wstrb),
    .wb         (wb),
    .ebreak     (ebreak)
  );

  rv_hazard u_hazard (
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_used (rs1_used),
    .rs2_used (rs2_used),
    .id_ex    (id_ex),
    .redirect (redirect),
    .hazard   (hazard)
  );

endmodule

`default_nettype wire

/* design/rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire rv_pkg::if_id_t      if_id,
  input  wire rv_pkg::mem_wb_t     wb,
  input  wire rv_pkg::hazard_ctl_t hazard,
  output rv_pkg::reg_idx_t        rs1,
  output rv_pkg::reg_idx_t        rs2,
  output logic                    rs1_used,
  output logic                    rs2_used,
  output rv_pkg::id_ex_t          id_ex
);
  import rv_pkg::*;

  instr_u instr;
  ctrl_t  ctrl;
  xlen_t  imm;
  xlen_t  rs1_data;
  xlen_t  rs2_data;

  // Shared funct3 decode for OP and OP-IMM
  function automatic alu_op_e funct_to_alu(logic [2:0] funct3, logic sub);
    case (funct3)
      F3_ADD:  return sub ? ALU_SUB : ALU_ADD;
      F3_SLT:  return ALU_SLT;
      F3_XOR:  return ALU_XOR;
      F3_OR:   return ALU_OR;
      F3_AND:  return ALU_AND;
      default: return ALU_ADD;
    endcase
  endfunction

  assign instr = if_id.instr;
  // Register fields sit at the same bits in every format that has them
  assign rs1   = instr.r.rs1;
  assign rs2   = instr.r.rs2;

  // ------------------------------------------------------------------------
  // Control and immediate
  // ------------------------------------------------------------------------
  always_comb begin
    ctrl     = '0;
    imm      = '0;
    rs1_used = 1'b0;
    rs2_used = 1'b0;
    case (instr.r.opcode)
      OP_REG: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = funct_to_alu(instr.r.funct3, instr.r.funct7[5]);
        rs1_used       = 1'b1;
        rs2_used       = 1'b1;
      end
      OP_IMM: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_b_imm = 1'b1;
        ctrl.alu_op    = funct_to_alu(instr.i.funct3, 1'b0);
        imm            = {{20{instr.i.imm[11]}}, instr.i.imm};
        rs1_used       = 1'b1;
      end
      OP_LUI: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_b_imm = 1'b1;
        ctrl.alu_op    = ALU_PASS_B;
        imm            = {instr.u.imm_31_12, 12'b0};
      end
      OP_LOAD: begin
        ctrl.reg_write = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.mem_byte  = (instr.i.funct3 == F3_LBU);
        ctrl.alu_b_imm = 1'b1;
        imm            = {{20{instr.i.imm[11]}}, instr.i.imm};
        rs1_used       = 1'b1;
      end
      OP_STORE: begin
        ctrl.mem_write = 1'b1;
        ctrl.mem_byte  = (instr.s.funct3 == F3_SB);
        ctrl.alu_b_imm = 1'b1;
        imm            = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
        rs1_used       = 1'b1;
        rs2_used       = 1'b1;
      end
      OP_BRANCH: begin
        // ALU forms the target, the compare runs beside it
        ctrl.is_branch = 1'b1;
        ctrl.branch_ne = instr.b.funct3[0];
        ctrl.alu_a_pc  = 1'b1;
        ctrl.alu_b_imm = 1'b1;
        imm = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
               instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
        rs1_used       = 1'b1;
        rs2_used       = 1'b1;
      end
      OP_JAL: begin
        ctrl.is_jump   = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.alu_a_pc  = 1'b1;
        ctrl.alu_b_imm = 1'b1;
        imm = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
               instr.j.imm_11, instr.j.imm_10_1, 1'b0};
      end
      OP_SYSTEM: begin
        // Only EBREAK, anything else here is a NOP
        ctrl.is_ebreak = (instr.i.imm == 12'd1) && (instr.i.funct3 == 3'b000);
      end
      default: begin
        ctrl = '0;
      end
    endcase
    // A bubble carries no control and reads nothing
    if (!if_id.valid) begin
      ctrl     = '0;
      rs1_used = 1'b0;
      rs2_used = 1'b0;
    end
  end

  rv_regfile u_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_addr (rs1),
    .rs2_addr (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb       (wb)
  );

  // ID/EX register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_ex <= '0;
    end else if (hazard.flush_execute || hazard.stall_decode) begin
      id_ex.valid <= 1'b0;
      id_ex.ctrl  <= '0;
    end else begin
      id_ex.valid    <= if_id.valid;
      id_ex.ctrl     <= ctrl;
      id_ex.pc       <= if_id.pc;
      id_ex.rs1      <= rs1;
      id_ex.rs2      <= rs2;
      id_ex.rd       <= instr.r.rd;
      id_ex.rs1_data <= rs1_data;
      id_ex.rs2_data <= rs2_data;
      id_ex.imm      <= imm;
    end
  end

endmodule

`default_nettype wire

/* design/rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire rv_pkg::id_ex_t  id_ex,
  input  wire rv_pkg::ex_mem_t mem_fwd,
  input  wire rv_pkg::mem_wb_t wb,
  output rv_pkg::redirect_t   redirect,
  output rv_pkg::ex_mem_t     ex_mem
);
  import rv_pkg::*;

  xlen_t rs1_val;
  xlen_t rs2_val;
  xlen_t op_a;
  xlen_t op_b;
  xlen_t alu_out;
  logic  operands_eq;

  // Youngest producer first, x0 never forwarded
  function automatic xlen_t forward(reg_idx_t idx, xlen_t reg_val);
    if (idx == '0) begin
      return reg_val;
    end
    if (mem_fwd.valid && mem_fwd.ctrl.reg_write && (mem_fwd.rd == idx)) begin
      return mem_fwd.alu_result;
    end
    if (wb.valid && wb.reg_write && (wb.rd == idx)) begin
      return wb.rd_data;
    end
    return reg_val;
  endfunction

  always_comb begin
    rs1_val = forward(id_ex.rs1, id_ex.rs1_data);
    rs2_val = forward(id_ex.rs2, id_ex.rs2_data);
  end

  assign op_a = id_ex.ctrl.alu_a_pc ? id_ex.pc : rs1_val;
  assign op_b = id_ex.ctrl.alu_b_imm ? id_ex.imm : rs2_val;

  // ------------------------------------------------------------------------
  // ALU
  // ------------------------------------------------------------------------
  always_comb begin
    case (id_ex.ctrl.alu_op)
      ALU_ADD:    alu_out = op_a + op_b;
      ALU_SUB:    alu_out = op_a - op_b;
      ALU_AND:    alu_out = op_a & op_b;
      ALU_OR:     alu_out = op_a | op_b;
      ALU_XOR:    alu_out = op_a ^ op_b;
      ALU_SLT:    alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_PASS_B: alu_out = op_b;
      default:    alu_out = '0;
    endcase
  end

  // Branch compare runs on the register operands, the ALU gives PC plus offset
  assign operands_eq = (rs1_val == rs2_val);

  // Bubbles leave decode with cleared control, so no valid term here
  assign redirect.taken  = id_ex.ctrl.is_jump ||
                           (id_ex.ctrl.is_branch && (operands_eq ^ id_ex.ctrl.branch_ne));
  assign redirect.target = alu_out;

  // EX/MEM register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_mem <= '0;
    end else begin
      ex_mem.valid      <= id_ex.valid;
      ex_mem.ctrl       <= id_ex.ctrl;
      ex_mem.rd         <= id_ex.rd;
      // JAL links PC plus four
      ex_mem.alu_result <= id_ex.ctrl.is_jump ? (id_ex.pc + 32'd4) : alu_out;
      ex_mem.store_data <= rs2_val;
    end
  end

  a_redirect_valid: assert property (
    @(posedge clk) disable iff (!rst_n) redirect.taken |-> id_ex.valid
  );

endmodule

`default_nettype wire

/* design/rv_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_fetch #(
  parameter rv_pkg::xlen_t RESET_PC = 32'h0000_0000
) (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire rv_pkg::redirect_t   redirect,
  input  wire rv_pkg::hazard_ctl_t hazard,
  output logic                imem_ren,
  output rv_pkg::xlen_t       imem_raddr,
  input  wire rv_pkg::xlen_t  imem_rdata,
  output rv_pkg::if_id_t      if_id
);
  import rv_pkg::*;

  xlen_t pc;
  xlen_t pc_next;

  // Redirect from execute wins over a load-use hold
  always_comb begin
    if (redirect.taken) begin
      pc_next = redirect.target;
    end else if (hazard.stall_fetch) begin
      pc_next = pc;
    end else begin
      pc_next = pc + 32'd4;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  // Memory answers in the same cycle, no read on a held PC
  assign imem_ren   = !hazard.stall_fetch;
  assign imem_raddr = pc;

  // IF/ID register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      if_id.valid <= 1'b0;
      if_id.pc    <= '0;
      if_id.instr <= nop_instr;
    end else if (hazard.flush_decode) begin
      // Squash the word fetched behind a taken branch or jump
      if_id.valid <= 1'b0;
      if_id.instr <= nop_instr;
    end else if (!hazard.stall_decode) begin
      if_id.valid <= 1'b1;
      if_id.pc    <= pc;
      if_id.instr <= imem_rdata;
    end
  end

  // Branch and jump targets from execute keep the PC word-aligned
  a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* design/rv_hazard.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_hazard (
  input  wire rv_pkg::reg_idx_t  rs1,
  input  wire rv_pkg::reg_idx_t  rs2,
  input  wire                   rs1_used,
  input  wire                   rs2_used,
  input  wire rv_pkg::id_ex_t    id_ex,
  input  wire rv_pkg::redirect_t redirect,
  output rv_pkg::hazard_ctl_t   hazard
);
  import rv_pkg::*;

  logic load_use;

  // Load in execute feeding the instruction in decode
  assign load_use = id_ex.valid && id_ex.ctrl.mem_read && (id_ex.rd != '0) &&
                    ((rs1_used && (rs1 == id_ex.rd)) ||
                     (rs2_used && (rs2 == id_ex.rd)));

  always_comb begin
    hazard = '0;
    if (redirect.taken) begin
      // Kill the two younger instructions
      hazard.flush_decode  = 1'b1;
      hazard.flush_execute = 1'b1;
    end else if (load_use) begin
      // Hold fetch and decode, bubble into execute
      hazard.stall_fetch   = 1'b1;
      hazard.stall_decode  = 1'b1;
      hazard.flush_execute = 1'b1;
    end
  end

endmodule

`default_nettype wire

/* design/rv_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_memory (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire rv_pkg::ex_mem_t ex_mem,
  output logic                dmem_ren,
  output rv_pkg::xlen_t       dmem_raddr,
  input  wire rv_pkg::xlen_t  dmem_rdata,
  output logic                dmem_we,
  output rv_pkg::xlen_t       dmem_waddr,
  output rv_pkg::xlen_t       dmem_wdata,
  output logic [3:0]          dmem_wstrb,
  output rv_pkg::mem_wb_t     wb,
  output logic                ebreak
);
  import rv_pkg::*;

  logic [1:0] lane;
  xlen_t      word_addr;
  xlen_t      load_shifted;
  xlen_t      load_data;
  logic       halted;

  assign lane      = ex_mem.alu_result[1:0];
  assign word_addr = {ex_mem.alu_result[31:2], 2'b00};

  // Halt covers an EBREAK in write-back too, so the store behind it is dropped
  assign halted = ebreak || (wb.valid && wb.is_ebreak);

  // ------------------------------------------------------------------------
  // Data memory ports
  // ------------------------------------------------------------------------
  assign dmem_ren   = ex_mem.valid && ex_mem.ctrl.mem_read;
  assign dmem_raddr = word_addr;
  assign dmem_we    = ex_mem.valid && ex_mem.ctrl.mem_write && !halted;
  assign dmem_waddr = word_addr;

  // SB moves its byte to the addressed lane
  assign dmem_wdata = ex_mem.ctrl.mem_byte ?
                      (xlen_t'(ex_mem.store_data[7:0]) << {lane, 3'b000}) :
                      ex_mem.store_data;
  assign dmem_wstrb = ex_mem.ctrl.mem_byte ? (4'b0001 << lane) : 4'b1111;

  // LBU, zero-extended
  assign load_shifted = dmem_rdata >> {lane, 3'b000};
  assign load_data    = ex_mem.ctrl.mem_byte ? {24'b0, load_shifted[7:0]} : dmem_rdata;

  // MEM/WB register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb <= '0;
    end else begin
      wb.valid     <= ex_mem.valid;
      wb.reg_write <= ex_mem.ctrl.reg_write;
      wb.is_ebreak <= ex_mem.ctrl.is_ebreak;
      wb.rd        <= ex_mem.rd;
      wb.rd_data   <= ex_mem.ctrl.mem_read ? load_data : ex_mem.alu_result;
    end
  end

  // Sticky until reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ebreak <= 1'b0;
    end else if (wb.valid && wb.is_ebreak) begin
      ebreak <= 1'b1;
    end
  end

  // Decode never marks one instruction as both load and store
  a_no_rd_wr: assert property (@(posedge clk) disable iff (!rst_n) !(dmem_we && dmem_ren));

endmodule

`default_nettype wire

/* design/rv_pkg.sv */
`default_nettype none

package rv_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [4:0]  reg_idx_t;

  // ------------------------------------------------------------------------
  // Encodings
  // ------------------------------------------------------------------------

  // Major opcodes of the supported instruction groups
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_JAL    = 7'b1101111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  // funct3 values, shared between OP and OP-IMM
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;
  // Memory widths: SB and LBU
  localparam logic [2:0] F3_SB  = 3'b000;
  localparam logic [2:0] F3_LBU = 3'b100;

  // ADDI x0, x0, 0
  localparam xlen_t nop_instr = 32'h0000_0013;

  // ------------------------------------------------------------------------
  // Instruction formats
  // ------------------------------------------------------------------------

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    opcode_e    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    opcode_e     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    opcode_e    opcode;
  } s_fmt_t;

  // Branch offset bits are scattered, bit 0 is implied
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_e    opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    reg_idx_t    rd;
    opcode_e     opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    reg_idx_t   rd;
    opcode_e    opcode;
  } j_fmt_t;

  // One fetched word, viewed through each format
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } instr_u;

  // ------------------------------------------------------------------------
  // Stage registers and control
  // ------------------------------------------------------------------------

  typedef struct packed {
    logic   valid;
    xlen_t  pc;
    instr_u instr;
  } if_id_t;

  typedef struct packed {
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    mem_byte;
    logic    alu_b_imm;
    logic    alu_a_pc;
    logic    is_branch;
    logic    branch_ne;
    logic    is_jump;
    logic    is_ebreak;
    alu_op_e alu_op;
  } ctrl_t;

  typedef struct packed {
    logic     valid;
    ctrl_t    ctrl;
    xlen_t    pc;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    xlen_t    rs1_data;
    xlen_t    rs2_data;
    xlen_t    imm;
  } id_ex_t;

  typedef struct packed {
    logic     valid;
    ctrl_t    ctrl;
    reg_idx_t rd;
    xlen_t    alu_result;
    xlen_t    store_data;
  } ex_mem_t;

  typedef struct packed {
    logic     valid;
    logic     reg_write;
    logic     is_ebreak;
    reg_idx_t rd;
    xlen_t    rd_data;
  } mem_wb_t;

  typedef struct packed {
    logic stall_fetch;
    logic stall_decode;
    logic flush_decode;
    logic flush_execute;
  } hazard_ctl_t;

  typedef struct packed {
    logic  taken;
    xlen_t target;
  } redirect_t;

endpackage

`default_nettype wire

/* design/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire rv_pkg::reg_idx_t rs1_addr,
  input  wire rv_pkg::reg_idx_t rs2_addr,
  output rv_pkg::xlen_t        rs1_data,
  output rv_pkg::xlen_t        rs2_data,
  input  wire rv_pkg::mem_wb_t  wb
);
  import rv_pkg::*;

  // x0 has no storage
  xlen_t regs [1:31];
  logic  wr_en;

  assign wr_en = wb.valid && wb.reg_write && (wb.rd != '0);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      regs[wb.rd] <= wb.rd_data;
    end
  end

  // Write-through: a same-cycle write is visible to decode
  function automatic xlen_t read_port(reg_idx_t addr);
    if (addr == '0) begin
      return '0;
    end
    if (wr_en && (wb.rd == addr)) begin
      return wb.rd_data;
    end
    return regs[addr];
  endfunction

  always_comb begin
    rs1_data = read_port(rs1_addr);
    rs2_data = read_port(rs2_addr);
  end

  // EBREAK reaches write-back without a register write
  a_ebreak_no_write: assert property (
    @(posedge clk) disable iff (!rst_n) (wb.valid && wb.is_ebreak) |-> !wb.reg_write
  );

endmodule

`default_nettype wire

/* rv_core.f */
design/rv_pkg.sv
design/rv_regfile.sv
design/rv_fetch.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_memory.sv
design/rv_hazard.sv
design/rv_core.sv
sim/rv_mem_model.sv
sim/rv_core_tb.sv

/* sim/rv_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;
  import rv_pkg::*;

  localparam int          CLK_PERIOD = 20;
  localparam int          PROG_LEN   = 38;
  localparam int          N_EXP      = 14;
  localparam int          MEM_WORDS  = 64;
  localparam int          DRAIN_CYC  = 10;
  // Three loads are each read by the very next instruction
  localparam int          N_LOAD_USE = 3;
  localparam logic [31:0] SEED       = 32'h377a703b;
  localparam logic [6:0]  OPC_LOAD   = 7'b0000011;
  localparam logic [6:0]  OPC_IMM    = 7'b0010011;

  // One expected write on the data port
  typedef struct packed {
    xlen_t      addr;
    xlen_t      data;
    logic [3:0] strb;
  } store_t;

  logic       clk   = 1'b0;
  logic       rst_n = 1'b0;
  logic       imem_ren;
  xlen_t      imem_raddr;
  xlen_t      imem_rdata;
  logic       dmem_ren;
  xlen_t      dmem_raddr;
  xlen_t      dmem_rdata;
  logic       dmem_we;
  xlen_t      dmem_waddr;
  xlen_t      dmem_wdata;
  logic [3:0] dmem_wstrb;
  logic       ebreak;

  xlen_t  prog       [PROG_LEN];
  xlen_t  data_init  [MEM_WORDS];
  store_t exp_stores [N_EXP];
  int     n_seen = 0;
  int     n_fetch_holds = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  rv_core #(
    .RESET_PC (32'h0000_0000)
  ) dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_ren   (imem_ren),
    .imem_raddr (imem_raddr),
    .imem_rdata (imem_rdata),
    .dmem_ren   (dmem_ren),
    .dmem_raddr (dmem_raddr),
    .dmem_rdata (dmem_rdata),
    .dmem_we    (dmem_we),
    .dmem_waddr (dmem_waddr),
    .dmem_wdata (dmem_wdata),
    .dmem_wstrb (dmem_wstrb),
    .ebreak     (ebreak)
  );

  rv_mem_model #(
    .DEPTH (MEM_WORDS)
  ) mem (
    .clk        (clk),
    .imem_ren   (imem_ren),
    .imem_raddr (imem_raddr),
    .imem_rdata (imem_rdata),
    .dmem_ren   (dmem_ren),
    .dmem_raddr (dmem_raddr),
    .dmem_rdata (dmem_rdata),
    .dmem_we    (dmem_we),
    .dmem_waddr (dmem_waddr),
    .dmem_wdata (dmem_wdata),
    .dmem_wstrb (dmem_wstrb)
  );

  // --------------------------------------------------------------------------
  // RV32I encodings, straight from the base ISA formats
  // --------------------------------------------------------------------------
  function automatic xlen_t r_word(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd,
                                   reg_idx_t rs1, reg_idx_t rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic xlen_t i_word(logic [6:0] opc, logic [2:0] f3, reg_idx_t rd,
                                   reg_idx_t rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic xlen_t s_word(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2,
                                   logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  // Offset in bytes, bit 0 dropped by the format
  function automatic xlen_t b_word(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2,
                                   logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic xlen_t u_word(reg_idx_t rd, logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic xlen_t j_word(reg_idx_t rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  // --------------------------------------------------------------------------
  // Program and expected stores
  // --------------------------------------------------------------------------
  task automatic build_program();
    prog[0]  = i_word(OPC_IMM, 3'b000, 5'd5, 5'd0, 12'hFF9);   // x5 = -7
    prog[1]  = u_word(5'd6, 20'h80000);
    prog[2]  = i_word(OPC_LOAD, 3'b010, 5'd1, 5'd0, 12'h000);
    // Load-use, one bubble expected
    prog[3]  = r_word(7'h00, 3'b000, 5'd2, 5'd1, 5'd5);
    prog[4]  = s_word(3'b010, 5'd0, 5'd2, 12'h040);
    // Dependent chain, operands from memory and write-back stages
    prog[5]  = r_word(7'h20, 3'b000, 5'd3, 5'd2, 5'd5);
    prog[6]  = r_word(7'h00, 3'b100, 5'd4, 5'd3, 5'd6);
    prog[7]  = r_word(7'h00, 3'b110, 5'd7, 5'd4, 5'd3);
    prog[8]  = s_word(3'b010, 5'd0, 5'd4, 12'h044);
    prog[9]  = s_word(3'b010, 5'd0, 5'd7, 12'h048);
    prog[10] = r_word(7'h00, 3'b111, 5'd8, 5'd7, 5'd6);
    prog[11] = r_word(7'h00, 3'b010, 5'd9, 5'd6, 5'd5);    // SLT, both negative
    prog[12] = r_word(7'h00, 3'b010, 5'd10, 5'd5, 5'd6);
    prog[13] = i_word(OPC_IMM, 3'b111, 5'd11, 5'd1, 12'h0F0);
    prog[14] = i_word(OPC_IMM, 3'b110, 5'd12, 5'd1, 12'hF00);
    prog[15] = i_word(OPC_IMM, 3'b100, 5'd13, 5'd1, 12'h555);
    prog[16] = s_word(3'b010, 5'd0, 5'd8, 12'h04C);
    prog[17] = s_word(3'b010, 5'd0, 5'd9, 12'h050);
    prog[18] = s_word(3'b010, 5'd0, 5'd10, 12'h054);
    prog[19] = s_word(3'b010, 5'd0, 5'd11, 12'h058);
    prog[20] = s_word(3'b010, 5'd0, 5'd12, 12'h05C);
    prog[21] = s_word(3'b010, 5'd0, 5'd13, 12'h060);
    prog[22] = s_word(3'b010, 5'd0, 5'd6, 12'h064);
    // Taken BEQ skips two stores
    prog[23] = b_word(3'b000, 5'd3, 5'd1, 13'd12);
    prog[24] = s_word(3'b010, 5'd0, 5'd5, 12'h068);
    prog[25] = s_word(3'b010, 5'd0, 5'd5, 12'h06C);
    prog[26] = b_word(3'b001, 5'd3, 5'd1, 13'd12);             // BNE falls through
    prog[27] = s_word(3'b010, 5'd0, 5'd1, 12'h070);
    prog[28] = j_word(5'd14, 21'd12);
    prog[29] = s_word(3'b010, 5'd0, 5'd5, 12'h074);
    prog[30] = s_word(3'b010, 5'd0, 5'd5, 12'h078);
    prog[31] = s_word(3'b010, 5'd0, 5'd14, 12'h07C);
    // SB into lane 1, then read back with LBU
    prog[32] = i_word(OPC_LOAD, 3'b010, 5'd15, 5'd0, 12'h004);
    prog[33] = s_word(3'b000, 5'd0, 5'd15, 12'h081);
    prog[34] = i_word(OPC_LOAD, 3'b100, 5'd16, 5'd0, 12'h081);
    prog[35] = s_word(3'b010, 5'd0, 5'd16, 12'h084);
    prog[36] = 32'h0010_0073;                                  // EBREAK
    prog[37] = s_word(3'b010, 5'd0, 5'd5, 12'h088);          // dropped after halt
  endtask

  task automatic build_expected();
    xlen_t d0;
    xlen_t d1;
    d0 = data_init[0];
    d1 = data_init[1];
    exp_stores[0]  = '{32'h040, d0 + 32'hFFFF_FFF9, 4'hF};
    exp_stores[1]  = '{32'h044, d0 ^ 32'h8000_0000, 4'hF};
    exp_stores[2]  = '{32'h048, d0 | 32'h8000_0000, 4'hF};
    exp_stores[3]  = '{32'h04C, (d0 | 32'h8000_0000) & 32'h8000_0000, 4'hF};
    exp_stores[4]  = '{32'h050, 32'd1, 4'hF};
    exp_stores[5]  = '{32'h054, 32'd0, 4'hF};
    exp_stores[6]  = '{32'h058, d0 & 32'h0000_00F0, 4'hF};
    exp_stores[7]  = '{32'h05C, d0 | 32'hFFFF_FF00, 4'hF};
    exp_stores[8]  = '{32'h060, d0 ^ 32'h0000_0555, 4'hF};
    exp_stores[9]  = '{32'h064, 32'h8000_0000, 4'hF};
    exp_stores[10] = '{32'h070, d0, 4'hF};
    // Link of the JAL at 0x70
    exp_stores[11] = '{32'h07C, 32'h0000_0074, 4'hF};
    exp_stores[12] = '{32'h080, {16'h0, d1[7:0], 8'h0}, 4'b0010};
    exp_stores[13] = '{32'h084, {24'h0, d1[7:0]}, 4'hF};
  endtask

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  task automatic abort_run();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic report_problem(input string msg);
    $display("%s", msg);
    abort_run();
  endtask

  task automatic check_word(input string name, input xlen_t got, input xlen_t want);
    if (got !== want) begin
      $display("FAIL %s (store %0d): got 0x%08h, expected 0x%08h", name, n_seen, got, want);
      abort_run();
    end
  endtask

  task automatic check_strobe(input string name, input logic [3:0] got,
                              input logic [3:0] want);
    if (got !== want) begin
      $display("FAIL %s (store %0d): got 0x%01h, expected 0x%01h", name, n_seen, got, want);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("FAIL %s: got 0x%01h, expected 0x%01h", name, got, want);
      abort_run();
    end
  endtask

  // Only the strobed lanes carry data
  task automatic check_store();
    store_t want;
    xlen_t  lane_mask;
    if (n_seen >= N_EXP) begin
      report_problem($sformatf("store to 0x%08h after the last expected store", dmem_waddr));
    end else begin
      want = exp_stores[n_seen];
      for (int b = 0; b < 4; b++) begin
        lane_mask[8*b +: 8] = {8{want.strb[b]}};
      end
      check_word("dmem_waddr", dmem_waddr, want.addr);
      check_strobe("dmem_wstrb", dmem_wstrb, want.strb);
      check_word("dmem_wdata", dmem_wdata & lane_mask, want.data & lane_mask);
      n_seen++;
    end
  endtask

  // Outputs settle between edges, sample mid-cycle
  always @(negedge clk) begin
    if (rst_n === 1'b1 && dmem_we === 1'b1) begin
      check_store();
    end
    // Fetch holds its PC only for a load-use stall
    if (rst_n === 1'b1 && imem_ren !== 1'b1) begin
      n_fetch_holds++;
    end
  end

  initial begin : run
    void'($urandom(SEED));
    build_program();
    for (int i = 0; i < MEM_WORDS; i++) begin
      data_init[i] = $urandom();
      mem.load_data(i, data_init[i]);
      mem.load_instr(i, (i < PROG_LEN) ? prog[i] : nop_instr);
    end
    build_expected();
    // Three rising edges in reset, outputs quiet
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_flag("ebreak", ebreak, 1'b0);
    check_flag("dmem_we", dmem_we, 1'b0);
    check_flag("dmem_ren", dmem_ren, 1'b0);
    @(posedge clk);
    rst_n <= 1'b1;
    while (ebreak !== 1'b1) begin
      @(negedge clk);
    end
    // Let the pipeline drain, no store may follow the halt
    repeat (DRAIN_CYC) @(negedge clk);
    check_flag("ebreak", ebreak, 1'b1);
    if (n_fetch_holds != N_LOAD_USE) begin
      report_problem($sformatf("FAIL imem_ren: low in 0x%0h cycles, expected 0x%0h",
                               n_fetch_holds, N_LOAD_USE));
    end else if (n_seen != N_EXP) begin
      report_problem($sformatf("only %0d of %0d expected stores seen", n_seen, N_EXP));
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

  // Twelve cycles per program word is far beyond the pipelined run time
  initial begin : watchdog
    #(PROG_LEN * 12 * CLK_PERIOD);
    report_problem("timeout, the core never halted on EBREAK");
  end

endmodule

`default_nettype wire

/* sim/rv_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_mem_model #(
  parameter int DEPTH = 64
) (
  input  wire                clk,
  input  wire                imem_ren,
  input  wire rv_pkg::xlen_t imem_raddr,
  output rv_pkg::xlen_t      imem_rdata,
  input  wire                dmem_ren,
  input  wire rv_pkg::xlen_t dmem_raddr,
  output rv_pkg::xlen_t      dmem_rdata,
  input  wire                dmem_we,
  input  wire rv_pkg::xlen_t dmem_waddr,
  input  wire rv_pkg::xlen_t dmem_wdata,
  input  wire [3:0]          dmem_wstrb
);
  import rv_pkg::*;

  localparam int AW = $clog2(DEPTH);

  // Separate instruction and data arrays, contents supplied by the testbench
  xlen_t imem [DEPTH];
  xlen_t dmem [DEPTH];

  // Word index inside the array
  function automatic logic [AW-1:0] word_idx(xlen_t addr);
    return addr[AW+1:2];
  endfunction

  // Addresses above the array read as empty
  function automatic logic in_range(xlen_t addr);
    return addr[31:AW+2] == '0;
  endfunction

  // Both ports answer in the same cycle
  assign imem_rdata = (imem_ren && in_range(imem_raddr)) ?
                      imem[word_idx(imem_raddr)] : nop_instr;
  assign dmem_rdata = (dmem_ren && in_range(dmem_raddr)) ?
                      dmem[word_idx(dmem_raddr)] : '0;

  // Byte lanes written only where the strobe is set
  always @(posedge clk) begin
    if (dmem_we && in_range(dmem_waddr)) begin
      for (int b = 0; b < 4; b++) begin
        if (dmem_wstrb[b]) begin
          dmem[word_idx(dmem_waddr)][8*b +: 8] <= dmem_wdata[8*b +: 8];
        end
      end
    end
  end

  task automatic load_instr(input int idx, input xlen_t word);
    imem[idx] = word;
  endtask

  task automatic load_data(input int idx, input xlen_t word);
    dmem[idx] = word;
  endtask

endmodule

`default_nettype wire
